/* src/wbw_pkg.sv */
// shared widths, depths, bus bundles and engine states for the burst write bridge
package wbw_pkg;

  // bus and burst field widths
  localparam int WB_ADR_W    = 30;  // word address
  localparam int WB_DAT_W    = 32;
  localparam int WB_SEL_W    = 4;   // one select per byte
  localparam int BURST_LEN_W = 4;   // beats minus one

  // fifo depth exponents
  localparam int CMD_DEPTH_LOG2  = 4;  // 16 commands
  localparam int BEAT_DEPTH_LOG2 = 5;  // 32 beats

  typedef logic [WB_ADR_W-1:0]    wb_adr_t;
  typedef logic [WB_DAT_W-1:0]    wb_dat_t;
  typedef logic [WB_SEL_W-1:0]    wb_sel_t;
  typedef logic [BURST_LEN_W-1:0] burst_len_t;

  // one burst command, start address in the upper bits
  typedef struct packed {
    wb_adr_t    adr;  // first word of the burst
    burst_len_t len;  // 0 means a single beat
  } burst_cmd_t;

  // one write beat
  typedef struct packed {
    wb_dat_t dat;
    wb_sel_t sel;  // byte lanes to write
  } wr_beat_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic    cyc;  // bus cycle in progress
    logic    stb;  // transfer request
    logic    we;   // always write here
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
  } wb_req_t;

  // fifo vector widths follow the structs
  localparam int CMD_W  = $bits(burst_cmd_t);
  localparam int BEAT_W = $bits(wr_beat_t);

  // write engine states
  typedef enum logic [1:0] {
    ENG_IDLE      = 2'd0,  // waiting for a command
    ENG_WAIT_BEAT = 2'd1,  // burst open, no beat yet
    ENG_STROBE    = 2'd2,  // stb high, waiting for ack
    ENG_GAP       = 2'd3   // one idle cycle between beats
  } eng_state_t;

endpackage

/* src/fifo_same_clock.sv */
// single clock FIFO with input register and show-ahead output stage, used for both streams
module fifo_same_clock #(
  parameter int DATA_WIDTH = 16,  // entry width
  parameter int DATA_DEPTH = 4    // log2 of ram entries
) (
  input  logic                  clk,
  input  logic                  rst,        // async, active high
  input  logic                  sync_rst,   // clears contents at the edge
  input  logic                  we,         // push data_in
  input  logic                  re,         // drop current head
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out,   // head, valid with nempty
  output logic                  nempty,
  output logic                  half_full   // top bit of fill, one edge late
);

  logic [DATA_WIDTH-1:0] ram [2**DATA_DEPTH];  // storage, no reset
  logic [DATA_WIDTH-1:0] in_reg;               // registered push data
  logic [DATA_WIDTH-1:0] out_reg;              // prefetched head
  logic [DATA_DEPTH-1:0] wa;                   // ram write pointer
  logic [DATA_DEPTH-1:0] ra;                   // ram read pointer
  logic [DATA_DEPTH-1:0] fill;                 // entries held in ram
  logic [DATA_DEPTH-1:0] next_fill;
  logic                  wem;                  // in_reg goes to ram this cycle
  logic                  rem;                  // ram to out_reg this cycle
  logic                  ram_nempty;           // ram has at least one entry
  logic                  out_full;             // out_reg holds a valid head

  // refill the output stage when it is empty or being consumed
  assign rem      = ram_nempty && (re || !out_full);
  assign data_out = out_reg;
  assign nempty   = out_full;

  always_comb begin
    case ({wem, rem})
      2'b10:   next_fill = fill + 1'b1;  // write only
      2'b01:   next_fill = fill - 1'b1;  // read only
      default: next_fill = fill;         // both or neither
    endcase
  end

  // control state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill       <= '0;
      wem        <= 1'b0;
      ram_nempty <= 1'b0;
      wa         <= '0;
      ra         <= '0;
      out_full   <= 1'b0;
      half_full  <= 1'b0;
    end else if (sync_rst) begin
      fill       <= '0;
      wem        <= 1'b0;
      ram_nempty <= 1'b0;
      wa         <= '0;
      ra         <= '0;
      out_full   <= 1'b0;
      half_full  <= fill[DATA_DEPTH-1];  // still tracks old fill
    end else begin
      fill       <= next_fill;
      wem        <= we;                      // ram write one cycle after push
      ram_nempty <= (next_fill != '0);
      half_full  <= fill[DATA_DEPTH-1];
      if (wem) begin
        wa <= wa + 1'b1;
      end
      if (rem) begin
        ra <= ra + 1'b1;
      end else if (!ram_nempty) begin
        ra <= wa;                            // resync pointers when idle
      end
      if (rem && !re) begin
        out_full <= 1'b1;                    // head loaded
      end else if (re && !rem) begin
        out_full <= 1'b0;                    // head taken, nothing behind
      end
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (we) begin
      in_reg <= data_in;
    end
    if (wem) begin
      ram[wa] <= in_reg;
    end
    if (rem) begin
      out_reg <= ram[ra];                    // prefetch next head
    end
  end

endmodule

/* src/wb_write_engine.sv */
// write engine: pairs burst commands with beats and runs Wishbone classic single writes
module wb_write_engine (
  input  logic                clk,
  input  logic                rst,         // async, active high
  input  logic                flush,       // abort burst at next edge
  input  wbw_pkg::burst_cmd_t cmd_head,    // command fifo head
  input  logic                cmd_valid,
  output logic                cmd_pop,
  input  wbw_pkg::wr_beat_t   beat_head,   // beat fifo head
  input  logic                beat_valid,
  output logic                beat_pop,
  output wbw_pkg::wb_req_t    wb,          // master outputs
  input  logic                wb_ack,
  output logic                burst_done   // pulse after last ack
);

  wbw_pkg::eng_state_t state;       // engine fsm
  wbw_pkg::wb_adr_t    cur_adr;     // address of the next beat
  wbw_pkg::burst_len_t beats_left;  // beats after the current one
  logic                cyc_q;
  logic                stb_q;
  logic                we_q;
  wbw_pkg::wb_adr_t    adr_q;       // bus payload, held during stb
  wbw_pkg::wb_dat_t    dat_q;
  wbw_pkg::wb_sel_t    sel_q;
  logic                beat_ack;    // current beat accepted
  logic                last_beat;
  logic                load_beat;   // beat head goes onto the bus

  assign beat_ack  = (state == wbw_pkg::ENG_STROBE) && stb_q && wb_ack;
  assign last_beat = (beats_left == '0);
  assign load_beat = (state == wbw_pkg::ENG_WAIT_BEAT) && beat_valid && !flush;

  // pops are single cycle, taken at the edge that consumes the head
  assign cmd_pop  = !flush && (state == wbw_pkg::ENG_IDLE) && cmd_valid;
  assign beat_pop = !flush && beat_ack;

  // bus bundle straight from registers
  assign wb.cyc = cyc_q;
  assign wb.stb = stb_q;
  assign wb.we  = we_q;
  assign wb.adr = adr_q;
  assign wb.dat = dat_q;
  assign wb.sel = sel_q;

  // control state and burst bookkeeping
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= wbw_pkg::ENG_IDLE;
      cyc_q      <= 1'b0;
      stb_q      <= 1'b0;
      we_q       <= 1'b0;
      burst_done <= 1'b0;
      cur_adr    <= '0;
      beats_left <= '0;
    end else begin
      burst_done <= 1'b0;                       // pulse by default
      if (flush) begin
        state <= wbw_pkg::ENG_IDLE;             // drop the burst
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
        we_q  <= 1'b0;
      end else begin
        case (state)
          wbw_pkg::ENG_IDLE: begin
            if (cmd_valid) begin
              cur_adr    <= cmd_head.adr;       // latch burst start
              beats_left <= cmd_head.len;
              state      <= wbw_pkg::ENG_WAIT_BEAT;
            end
          end
          wbw_pkg::ENG_WAIT_BEAT: begin
            if (beat_valid) begin
              cyc_q <= 1'b1;                    // opens cycle on first beat
              stb_q <= 1'b1;
              we_q  <= 1'b1;
              state <= wbw_pkg::ENG_STROBE;
            end
          end
          wbw_pkg::ENG_STROBE: begin
            if (beat_ack) begin
              stb_q   <= 1'b0;
              we_q    <= 1'b0;
              cur_adr <= cur_adr + 1'b1;        // next word
              if (last_beat) begin
                cyc_q      <= 1'b0;             // burst finished
                burst_done <= 1'b1;
                state      <= wbw_pkg::ENG_IDLE;
              end else begin
                beats_left <= beats_left - 1'b1;
                state      <= wbw_pkg::ENG_GAP;
              end
            end
          end
          wbw_pkg::ENG_GAP: begin
            state <= wbw_pkg::ENG_WAIT_BEAT;    // cyc stays high
          end
          default: begin
            state <= wbw_pkg::ENG_IDLE;
          end
        endcase
      end
    end
  end

  // payload registers, loaded once per beat and held until ack
  always_ff @(posedge clk) begin
    if (load_beat) begin
      adr_q <= cur_adr;
      dat_q <= beat_head.dat;
      sel_q <= beat_head.sel;
    end
  end

endmodule

/* src/wb_burst_writer.sv */
// top of the burst write bridge: command and beat FIFOs feeding the Wishbone write engine
module wb_burst_writer (
  input  logic                clk,
  input  logic                rst,         // async, active high
  input  logic                flush,       // clears fifos and aborts burst
  input  logic                cmd_push,    // only while cmd_room
  input  wbw_pkg::burst_cmd_t cmd,
  output logic                cmd_room,
  input  logic                beat_push,   // only while beat_room
  input  wbw_pkg::wr_beat_t   beat,
  output logic                beat_room,
  output wbw_pkg::wb_req_t    wb,          // wishbone master
  input  logic                wb_ack,
  output logic                burst_done
);

  logic [wbw_pkg::CMD_W-1:0]  cmd_q;       // command fifo head
  logic                       cmd_nempty;
  logic                       cmd_re;
  logic                       cmd_half;
  logic [wbw_pkg::BEAT_W-1:0] beat_q;      // beat fifo head
  logic                       beat_nempty;
  logic                       beat_re;
  logic                       beat_half;

  // half_full lags, so half the depth stays as margin
  assign cmd_room  = !cmd_half;
  assign beat_room = !beat_half;

  fifo_same_clock #(
    .DATA_WIDTH (wbw_pkg::CMD_W),
    .DATA_DEPTH (wbw_pkg::CMD_DEPTH_LOG2)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .sync_rst  (flush),
    .we        (cmd_push),
    .re        (cmd_re),
    .data_in   (cmd),                       // struct packs as vector
    .data_out  (cmd_q),
    .nempty    (cmd_nempty),
    .half_full (cmd_half)
  );

  fifo_same_clock #(
    .DATA_WIDTH (wbw_pkg::BEAT_W),
    .DATA_DEPTH (wbw_pkg::BEAT_DEPTH_LOG2)
  ) u_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .sync_rst  (flush),
    .we        (beat_push),
    .re        (beat_re),
    .data_in   (beat),
    .data_out  (beat_q),
    .nempty    (beat_nempty),
    .half_full (beat_half)
  );

  wb_write_engine u_engine (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .cmd_head   (wbw_pkg::burst_cmd_t'(cmd_q)),
    .cmd_valid  (cmd_nempty),
    .cmd_pop    (cmd_re),
    .beat_head  (wbw_pkg::wr_beat_t'(beat_q)),
    .beat_valid (beat_nempty),
    .beat_pop   (beat_re),
    .wb         (wb),
    .wb_ack     (wb_ack),
    .burst_done (burst_done)
  );

endmodule

/* testbench/wb_burst_writer_assert.sv */
// protocol and reset assertions for the burst write bridge, bound into the top level
module wb_burst_writer_assert (
  input logic                clk,
  input logic                rst,
  input logic                flush,
  input wbw_pkg::wb_req_t    wb,
  input logic                wb_ack,
  input logic                burst_done,
  input logic                cmd_room,
  input logic                beat_room,
  input wbw_pkg::eng_state_t state,      // engine fsm
  input logic                cmd_pop,
  input wbw_pkg::burst_cmd_t cmd_head
);

  timeunit 1ns;
  timeprecision 1ps;

  int               fail_count = 0;  // read by the testbench
  wbw_pkg::wb_adr_t start_adr;       // start of the open burst
  wbw_pkg::wb_adr_t last_adr;        // address of the last acked beat
  logic             acked_any;       // a beat was acked in this cyc period

  // shadow of burst addressing
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_adr <= '0;
      last_adr  <= '0;
      acked_any <= 1'b0;
    end else begin
      if (cmd_pop) begin
        start_adr <= cmd_head.adr;         // command taken
      end
      if (!wb.cyc) begin
        acked_any <= 1'b0;                 // cycle closed
      end else if (wb.stb && wb_ack) begin
        acked_any <= 1'b1;
        last_adr  <= wb.adr;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |-> !wb.cyc && !wb.stb && !burst_done)
    else begin $error("bus active during reset"); fail_count++; end

  a_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !wb.cyc && !wb.stb && !burst_done && cmd_room && beat_room)
    else begin $error("bad state right after reset"); fail_count++; end

  a_stb_cyc_we: assert property (@(posedge clk) disable iff (rst) wb.stb |-> wb.cyc && wb.we)
    else begin $error("stb without cyc or we"); fail_count++; end

  a_payload_hold: assert property (@(posedge clk) disable iff (rst)
      wb.stb && !wb_ack |=> $stable(wb.adr) && $stable(wb.dat) && $stable(wb.sel))
    else begin $error("payload moved while waiting for ack"); fail_count++; end

  a_stb_drop: assert property (@(posedge clk) disable iff (rst) wb.stb && wb_ack |=> !wb.stb)
    else begin $error("stb still high after ack"); fail_count++; end

  // each beat one word above the last, first beat at the burst start
  a_addr_step: assert property (@(posedge clk) disable iff (rst)
      $rose(wb.stb) |-> wb.adr == (acked_any ? wbw_pkg::wb_adr_t'(last_adr + 1'b1) : start_adr))
    else begin $error("beat address out of sequence"); fail_count++; end

  a_idle_no_cyc: assert property (@(posedge clk) disable iff (rst)
      state == wbw_pkg::ENG_IDLE |-> !wb.cyc)
    else begin $error("cyc high with engine idle"); fail_count++; end

  a_strobe_stb: assert property (@(posedge clk) disable iff (rst)
      state == wbw_pkg::ENG_STROBE |-> wb.stb)
    else begin $error("strobe state without stb"); fail_count++; end

  a_flush_abort: assert property (@(posedge clk) disable iff (rst)
      flush |=> !wb.cyc && !wb.stb && !burst_done)
    else begin $error("burst survived flush"); fail_count++; end

endmodule

bind wb_burst_writer wb_burst_writer_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .flush      (flush),
  .wb         (wb),
  .wb_ack     (wb_ack),
  .burst_done (burst_done),
  .cmd_room   (cmd_room),
  .beat_room  (beat_room),
  .state      (u_engine.state),
  .cmd_pop    (u_engine.cmd_pop),
  .cmd_head   (u_engine.cmd_head)
);

/* testbench/tb_wb_burst_writer.sv */
// testbench for the burst write bridge: stimulus, memory slave, image compare and watchdog
module tb_wb_burst_writer;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_BURSTS = 64;
  localparam int WATCH_NS = N_BURSTS * 16 * 6 * 20 + 60000;  // main load plus side tests

  logic                clk = 1'b0;
  logic                rst;
  logic                flush;
  logic                cmd_push;
  wbw_pkg::burst_cmd_t cmd;
  logic                cmd_room;
  logic                beat_push;
  wbw_pkg::wr_beat_t   beat;
  logic                beat_room;
  wbw_pkg::wb_req_t    wb;
  logic                wb_ack;
  logic                burst_done;

  int          seed = 44319;
  logic [31:0] mem [1024];      // slave memory
  logic [31:0] exp_mem [1024];  // expected image
  int          writes = 0;      // acked beats seen by the slave
  int          done_count = 0;  // burst_done pulses
  logic        hold_ack = 1'b0; // slave stall
  logic        cmd_fell = 1'b0;
  logic        beat_fell = 1'b0;
  logic [31:0] last_dat [16];   // beats of the latest burst
  logic [3:0]  last_sel [16];

  wb_burst_writer dut (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .cmd_push   (cmd_push),
    .cmd        (cmd),
    .cmd_room   (cmd_room),
    .beat_push  (beat_push),
    .beat       (beat),
    .beat_room  (beat_room),
    .wb         (wb),
    .wb_ack     (wb_ack),
    .burst_done (burst_done)
  );

  always #10 clk = !clk;  // 20 ns period

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  // byte lane merge of a write into an old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = dat[8*b +: 8];
    end
    return res;
  endfunction

  // wishbone slave, ack after 1 to 4 cycles
  initial begin : slave_model
    int          wait_left;
    logic [9:0]  s_adr;
    logic [31:0] s_dat;
    logic [3:0]  s_sel;
    wb_ack = 1'b0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      #1;
      if (wb_ack) begin                   // beat completed at this edge
        mem[s_adr] = merge_bytes(mem[s_adr], s_dat, s_sel);
        writes++;
        wb_ack = 1'b0;
        wait_left = 0;
      end else if (!wb.stb) begin
        wait_left = 0;
      end else if (!hold_ack) begin
        if (wait_left == 0) wait_left = 1 + ($unsigned($random(seed)) % 4);
        wait_left--;
        if (wait_left == 0) begin
          s_adr = wb.adr[9:0];
          s_dat = wb.dat;
          s_sel = wb.sel;
          wb_ack = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (burst_done) done_count++;
    if (!rst && !cmd_room) cmd_fell = 1'b1;
    if (!rst && !beat_room) beat_fell = 1'b1;
    if (cmd_push && !cmd_room) abort_run($sformatf("FAIL %0t: command pushed without room", $time));
    if (beat_push && !beat_room) abort_run($sformatf("FAIL %0t: beat pushed without room", $time));
    if (dut.u_assert.fail_count != 0) abort_run("an assertion in the bound checker failed");
  end

  initial begin : watchdog
    #(WATCH_NS * 1ns);
    abort_run("timeout: the run did not finish in time");
  end

  // called at edge plus 2, returns at edge plus 2
  task automatic push_cmd(input wbw_pkg::wb_adr_t adr, input int len);
    while (!cmd_room) begin
      @(posedge clk);
      #2;
    end
    cmd.adr = adr;
    cmd.len = wbw_pkg::burst_len_t'(len);
    cmd_push = 1'b1;
    @(posedge clk);
    #2;
    cmd_push = 1'b0;
  endtask

  task automatic push_beat(input logic [31:0] dat, input logic [3:0] sel);
    while (!beat_room) begin
      @(posedge clk);
      #2;
    end
    beat.dat = dat;
    beat.sel = sel;
    beat_push = 1'b1;
    @(posedge clk);
    #2;
    beat_push = 1'b0;
  endtask

  // random beats, optionally folded into the expected image
  task automatic push_burst(input int base, input int len, input bit track);
    push_cmd(wbw_pkg::wb_adr_t'(base), len);
    for (int k = 0; k <= len; k++) begin
      last_dat[k] = $random(seed);
      last_sel[k] = 4'($random(seed));
      if (track) exp_mem[base + k] = merge_bytes(exp_mem[base + k], last_dat[k], last_sel[k]);
      push_beat(last_dat[k], last_sel[k]);
    end
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic compare_image;
    for (int a = 0; a < 1024; a++) begin
      if (mem[a] !== exp_mem[a]) begin
        abort_run($sformatf("FAIL %0t: word %0d is %h, expected %h", $time, a, mem[a], exp_mem[a]));
      end
    end
  endtask

  initial begin : main
    int n_cmd;
    int n_kept;
    int w0;
    int d0;
    rst = 1'b1;
    flush = 1'b0;
    cmd_push = 1'b0;
    cmd = '0;
    beat_push = 1'b0;
    beat = '0;
    for (int a = 0; a < 1024; a++) begin
      mem[a] = 32'h5a00_0000 ^ (a * 32'h0001_9e37);  // address dependent fill
      exp_mem[a] = mem[a];
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;

    // data integrity, 64 bursts in disjoint 16 word slots
    for (int i = 0; i < N_BURSTS; i++) begin
      push_burst(i * 16, $unsigned($random(seed)) % 16, 1'b1);
    end
    wait_done(N_BURSTS);
    compare_image();

    // back-pressure, slave stalled while both streams fill
    hold_ack = 1'b1;
    cmd_fell = 1'b0;
    beat_fell = 1'b0;
    d0 = done_count;
    n_cmd = 0;
    fork
      begin
        repeat (40) @(posedge clk);
        #2;
        hold_ack = 1'b0;
      end
      begin
        while (cmd_room && n_cmd < 15) begin
          push_cmd(wbw_pkg::wb_adr_t'(n_cmd * 2), 1);
          n_cmd++;
        end
        for (int k = 0; k < 2 * n_cmd; k++) begin
          last_dat[0] = $random(seed);
          exp_mem[k] = merge_bytes(exp_mem[k], last_dat[0], 4'hf);
          push_beat(last_dat[0], 4'hf);
        end
      end
    join
    if (!cmd_fell || !beat_fell) abort_run($sformatf("FAIL %0t: room did not fall", $time));
    wait_done(d0 + n_cmd);
    compare_image();

    // starved beats, cyc held with stb low
    d0 = done_count;
    push_burst(100, 0, 1'b1);  // single beat burst
    wait_done(d0 + 1);
    w0 = writes;
    push_cmd(wbw_pkg::wb_adr_t'(200), 3);
    push_beat(32'hcafe_0001, 4'hf);
    while (writes == w0) begin
      @(posedge clk);
      #2;
    end
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      #2;
      if (!wb.cyc || wb.stb || writes != w0 + 1) begin
        abort_run($sformatf("FAIL %0t: bus moved while beats were starved", $time));
      end
    end
    exp_mem[200] = 32'hcafe_0001;
    for (int k = 1; k < 4; k++) begin
      exp_mem[200 + k] = 32'hcafe_0000 + k;
      push_beat(32'hcafe_0000 + k, 4'hf);
    end
    wait_done(d0 + 2);
    compare_image();

    // flush in the middle of a 16 beat burst
    d0 = done_count;
    w0 = writes;
    push_burst(900, 15, 1'b0);
    while (writes - w0 < 3 || wb_ack) begin
      @(posedge clk);
      #2;
    end
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    if (wb.cyc) abort_run($sformatf("FAIL %0t: cyc still high after flush", $time));
    n_kept = writes - w0;  // beats acked before the flush
    for (int k = 0; k < n_kept; k++) begin
      exp_mem[900 + k] = merge_bytes(exp_mem[900 + k], last_dat[k], last_sel[k]);
    end
    repeat (10) @(posedge clk);
    #2;
    if (done_count != d0) abort_run($sformatf("FAIL %0t: done pulse for flushed burst", $time));
    if (writes != w0 + n_kept) begin
      abort_run($sformatf("FAIL %0t: write acked after flush", $time));
    end
    push_burst(960, 4, 1'b1);
    wait_done(d0 + 1);
    compare_image();

    if (dut.u_assert.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("an assertion in the bound checker failed");
    end
  end

endmodule

/* tb.f */
src/wbw_pkg.sv
src/fifo_same_clock.sv
src/wb_write_engine.sv
src/wb_burst_writer.sv
testbench/wb_burst_writer_assert.sv
testbench/tb_wb_burst_writer.sv

/* run.sh */
#!/bin/sh
# build and run the burst write bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f tb.f \
  --top-module tb_wb_burst_writer \
  -o tb_sim

# keep running past assertion errors so the testbench reports them itself
./obj_dir/tb_sim +verilator+error+limit+1000 | grep "Everything OK"
